// ==== dv/frontend_assertions.sv ====
// Front-end bound assertions

`timescale 1ns/100ps

`include "fe_params.svh"

module frontend_assertions import fe_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       redirect_i,
    input logic       fetch_req_i,
    input vaddr_t     fetch_addr_i,
    input logic       out_valid_i,
    input slot_mask_t out_slot_valid_i
);

    // ------------------------------------------------------------
    // output stage
    // ------------------------------------------------------------
    // no live slot without a valid block
    slot_mask_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !out_valid_i |-> out_slot_valid_i == '0)
        else $error("slot mask set while the output block is not valid");

    // ------------------------------------------------------------
    // fetch request side
    // ------------------------------------------------------------
    // blocks are fetched on 8 byte boundaries, only a redirect may land in between
    fetch_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_req_i && !$past(redirect_i) |-> fetch_addr_i[`FE_SLOT_SHIFT-1:0] == '0)
        else $error("fetch address not block aligned");

    // once requests start they never pause
    fetch_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_req_i |=> fetch_req_i)
        else $error("fetch request dropped after reset");

endmodule

bind frontend_top frontend_assertions i_frontend_assertions (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .redirect_i       (redirect_i),
    .fetch_req_i      (fetch_req_o),
    .fetch_addr_i     (fetch_addr_o),
    .out_valid_i      (out_valid_o),
    .out_slot_valid_i (out_slot_valid_o)
);

// ==== dv/frontend_tb.sv ====
// Front-end testbench

`timescale 1ns/100ps

`include "fe_params.svh"

module frontend_tb import fe_pkg::*; ();

    localparam int     CLK_PERIOD = 4;
    localparam int     RST_CYCLES = 3;
    localparam int     NUM_ROWS   = 8;
    localparam int     SEED       = 30;
    localparam vaddr_t BOOT_ADDR  = 32'h8000_0000;

    // one fetch response with everything expected from it
    typedef struct packed {
        vaddr_t      addr;
        fetch_data_t data;
        logic        redir;
        vaddr_t      redir_addr;
        logic        exp_valid;
        slot_mask_t  exp_mask;
        cf_e         exp_cf0;
        cf_e         exp_cf1;
        logic        exp_taken;
        vaddr_t      exp_target;
        vaddr_t      exp_npc;
    } row_t;

    logic                             clk_i;
    logic                             rst_ni;
    vaddr_t                           boot_addr_i;
    logic                             redirect_i;
    vaddr_t                           redirect_addr_i;
    logic                             rsp_valid_i;
    vaddr_t                           rsp_addr_i;
    fetch_data_t                      rsp_data_i;
    logic                             fetch_req_o;
    vaddr_t                           fetch_addr_o;
    logic                             out_valid_o;
    vaddr_t                           out_addr_o;
    instr_t [`FE_INSTR_PER_FETCH-1:0] out_instr_o;
    slot_mask_t                       out_slot_valid_o;
    cf_e    [`FE_INSTR_PER_FETCH-1:0] out_cf_o;
    logic                             out_taken_o;
    vaddr_t                           out_target_o;

    row_t  rows [NUM_ROWS];
    string row_name [NUM_ROWS];
    int    errors;
    int    tests_failed;

    frontend_top uut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .boot_addr_i      (boot_addr_i),
        .redirect_i       (redirect_i),
        .redirect_addr_i  (redirect_addr_i),
        .rsp_valid_i      (rsp_valid_i),
        .rsp_addr_i       (rsp_addr_i),
        .rsp_data_i       (rsp_data_i),
        .fetch_req_o      (fetch_req_o),
        .fetch_addr_o     (fetch_addr_o),
        .out_valid_o      (out_valid_o),
        .out_addr_o       (out_addr_o),
        .out_instr_o      (out_instr_o),
        .out_slot_valid_o (out_slot_valid_o),
        .out_cf_o         (out_cf_o),
        .out_taken_o      (out_taken_o),
        .out_target_o     (out_target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // watchdog, generous budget per row on top of reset
    initial begin
        #((NUM_ROWS * 6 + RST_CYCLES) * CLK_PERIOD);
        $display("timeout, the tests did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // instruction encoders, RV32I formats
    // ------------------------------------------------------------
    // beq x1, x2, imm
    function automatic instr_t enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // jal x1, imm
    function automatic instr_t enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    // jalr x1, imm(x1)
    function automatic instr_t enc_jalr(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, 7'b1100111};
    endfunction

    // random op-imm word, never control flow
    function automatic instr_t plain_word();
        instr_t w;
        w      = $urandom();
        w[6:0] = 7'b0010011;
        return w;
    endfunction

    task automatic report_mismatch(input string name, input string exp, input string act);
        errors++;
        $display("Fail at %0d ns: %s expected %s actual %s", $time, name, exp, act);
    endtask

    // ------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------
    // columns: addr, data {slot1, slot0}, redirect, redirect addr, valid, mask,
    // cf slot0, cf slot1, taken, target, next fetch address
    // fetch runs on from the boot address in steps of 8, three edges per row
    task automatic build_table();
        row_name[0] = "two plain slots";
        rows[0] = '{32'h1000, {plain_word(), plain_word()}, 1'b0, 32'h0,
                    1'b1, 2'b11, CF_NONE, CF_NONE, 1'b0, 32'h0, 32'h8000_0030};
        row_name[1] = "backward branch in slot 0";
        rows[1] = '{32'h1100, {plain_word(), enc_branch(-13'sd32)}, 1'b0, 32'h0,
                    1'b1, 2'b01, CF_BRANCH, CF_NONE, 1'b1, 32'h10E0, 32'h10E0};
        row_name[2] = "forward branch in slot 0";
        rows[2] = '{32'h1200, {plain_word(), enc_branch(13'sd64)}, 1'b0, 32'h0,
                    1'b1, 2'b11, CF_BRANCH, CF_NONE, 1'b0, 32'h0, 32'h10F8};
        row_name[3] = "jal in slot 1";
        rows[3] = '{32'h1300, {enc_jal(21'h1FC), plain_word()}, 1'b0, 32'h0,
                    1'b1, 2'b11, CF_NONE, CF_JUMP, 1'b1, 32'h1500, 32'h1500};
        row_name[4] = "jalr in slot 0";
        rows[4] = '{32'h1400, {plain_word(), enc_jalr(12'h010)}, 1'b0, 32'h0,
                    1'b1, 2'b11, CF_JALR, CF_NONE, 1'b0, 32'h0, 32'h1518};
        row_name[5] = "both slots taken, slot 0 wins";
        rows[5] = '{32'h1500, {enc_jal(21'h100), enc_branch(-13'sd8)}, 1'b0, 32'h0,
                    1'b1, 2'b01, CF_BRANCH, CF_JUMP, 1'b1, 32'h14F8, 32'h14F8};
        // the jal would predict 0x1680, the redirect must win
        row_name[6] = "redirect while jal in flight";
        rows[6] = '{32'h1600, {plain_word(), enc_jal(21'h080)}, 1'b1, 32'h2004,
                    1'b0, 2'b00, CF_JUMP, CF_NONE, 1'b0, 32'h0, 32'h2004};
        row_name[7] = "plain block after redirect";
        rows[7] = '{32'h2000, {plain_word(), plain_word()}, 1'b0, 32'h0,
                    1'b1, 2'b11, CF_NONE, CF_NONE, 1'b0, 32'h0, 32'h2018};
    endtask

    // boot address on the first edge out of reset, then plain steps of 8
    task automatic check_boot();
        vaddr_t exp_addr;
        int     errs_before;
        errs_before = errors;
        exp_addr    = BOOT_ADDR;
        for (int n = 0; n < 4; n++) begin
            @(posedge clk_i);
            #2;
            if (fetch_req_o !== 1'b1)
                report_mismatch("fetch_req_o", "1", $sformatf("%b", fetch_req_o));
            if (fetch_addr_o !== exp_addr)
                report_mismatch("fetch_addr_o", $sformatf("%h", exp_addr),
                                $sformatf("%h", fetch_addr_o));
            exp_addr = exp_addr + 32'd8;
        end
        if (errors != errs_before)
            tests_failed++;
        $display("boot and sequential fetch: %s", (errors == errs_before) ? "ok" : "mismatch");
        @(posedge clk_i);
        #1;
    endtask

    // ------------------------------------------------------------
    // one row: strobe, optional redirect a cycle later, check after 2 edges
    // ------------------------------------------------------------
    task automatic run_row(input int idx);
        row_t r;
        int   errs_before;
        r           = rows[idx];
        errs_before = errors;
        rsp_valid_i = 1'b1;
        rsp_addr_i  = r.addr;
        rsp_data_i  = r.data;
        @(posedge clk_i);
        #1;
        // block sits in the fetch register now
        rsp_valid_i     = 1'b0;
        redirect_i      = r.redir;
        redirect_addr_i = r.redir_addr;
        @(posedge clk_i);
        #1;
        redirect_i = 1'b0;
        #1;
        if (out_valid_o !== r.exp_valid)
            report_mismatch("out_valid_o", $sformatf("%b", r.exp_valid),
                            $sformatf("%b", out_valid_o));
        if (out_slot_valid_o !== r.exp_mask)
            report_mismatch("out_slot_valid_o", $sformatf("%b", r.exp_mask),
                            $sformatf("%b", out_slot_valid_o));
        if (out_taken_o !== r.exp_taken)
            report_mismatch("out_taken_o", $sformatf("%b", r.exp_taken),
                            $sformatf("%b", out_taken_o));
        if (fetch_addr_o !== r.exp_npc)
            report_mismatch("fetch_addr_o", $sformatf("%h", r.exp_npc),
                            $sformatf("%h", fetch_addr_o));
        // payload only means something for a block that got through
        if (r.exp_valid) begin
            if (out_addr_o !== (r.addr & ~32'h7))
                report_mismatch("out_addr_o", $sformatf("%h", r.addr & ~32'h7),
                                $sformatf("%h", out_addr_o));
            if (out_instr_o[0] !== r.data[31:0])
                report_mismatch("out_instr_o[0]", $sformatf("%h", r.data[31:0]),
                                $sformatf("%h", out_instr_o[0]));
            if (out_instr_o[1] !== r.data[63:32])
                report_mismatch("out_instr_o[1]", $sformatf("%h", r.data[63:32]),
                                $sformatf("%h", out_instr_o[1]));
            if (out_cf_o[0] !== r.exp_cf0)
                report_mismatch("out_cf_o[0]", $sformatf("%0d", r.exp_cf0),
                                $sformatf("%0d", out_cf_o[0]));
            if (out_cf_o[1] !== r.exp_cf1)
                report_mismatch("out_cf_o[1]", $sformatf("%0d", r.exp_cf1),
                                $sformatf("%0d", out_cf_o[1]));
            if (r.exp_taken && out_target_o !== r.exp_target)
                report_mismatch("out_target_o", $sformatf("%h", r.exp_target),
                                $sformatf("%h", out_target_o));
        end
        if (errors != errs_before)
            tests_failed++;
        $display("row %0d %s: %s", idx, row_name[idx], (errors == errs_before) ? "ok" : "mismatch");
        @(posedge clk_i);
        #1;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        errors          = 0;
        tests_failed    = 0;
        rst_ni          = 1'b0;
        boot_addr_i     = BOOT_ADDR;
        redirect_i      = 1'b0;
        redirect_addr_i = '0;
        rsp_valid_i     = 1'b0;
        rsp_addr_i      = '0;
        rsp_data_i      = '0;
        build_table();
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_boot();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("tests %0d, failed %0d, mismatches %0d", NUM_ROWS + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/branch_select.sv ====
// Static branch selector

`timescale 1ns/100ps

`include "fe_params.svh"

module branch_select import fe_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   flush_i,
    // block from the fetch register
    input  logic                                   blk_valid_i,
    input  vaddr_t                                 blk_addr_i,
    input  instr_t [`FE_INSTR_PER_FETCH-1:0]       slot_instr_i,
    input  vaddr_t [`FE_INSTR_PER_FETCH-1:0]       slot_addr_i,
    // scanner results
    input  cf_e    [`FE_INSTR_PER_FETCH-1:0]       slot_cf_i,
    input  vaddr_t [`FE_INSTR_PER_FETCH-1:0]       slot_imm_i,
    // prediction back to the pc generator
    output logic                                   pred_taken_o,
    output vaddr_t                                 pred_target_o,
    // registered front-end output
    output logic                                   out_valid_o,
    output vaddr_t                                 out_addr_o,
    output instr_t [`FE_INSTR_PER_FETCH-1:0]       out_instr_o,
    output slot_mask_t                             out_slot_valid_o,
    output cf_e    [`FE_INSTR_PER_FETCH-1:0]       out_cf_o,
    output logic                                   out_taken_o,
    output vaddr_t                                 out_target_o
);

    slot_mask_t slot_taken;
    slot_mask_t slot_mask;
    logic       seen_taken;

    // ------------------------------------------------------------
    // static prediction
    // ------------------------------------------------------------
    // jal always taken, branch taken when it points backwards
    // walk from the top slot down so the lowest taken slot wins
    always_comb begin
        slot_taken    = '0;
        pred_taken_o  = 1'b0;
        pred_target_o = '0;
        for (int i = `FE_INSTR_PER_FETCH - 1; i >= 0; i--) begin
            slot_taken[i] = blk_valid_i &
                            ((slot_cf_i[i] == CF_JUMP) |
                             ((slot_cf_i[i] == CF_BRANCH) & slot_imm_i[i][`FE_VLEN-1]));
            if (slot_taken[i]) begin
                pred_taken_o  = 1'b1;
                pred_target_o = slot_addr_i[i] + slot_imm_i[i];
            end
        end
    end

    // slots behind a taken one never execute
    always_comb begin
        slot_mask  = '0;
        seen_taken = 1'b0;
        for (int i = 0; i < `FE_INSTR_PER_FETCH; i++) begin
            slot_mask[i] = blk_valid_i & ~seen_taken;
            seen_taken   = seen_taken | slot_taken[i];
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    // redirect drops the block that is about to leave
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_o      <= 1'b0;
            out_slot_valid_o <= '0;
            out_taken_o      <= 1'b0;
        end else if (flush_i) begin
            out_valid_o      <= 1'b0;
            out_slot_valid_o <= '0;
            out_taken_o      <= 1'b0;
        end else begin
            out_valid_o      <= blk_valid_i;
            out_slot_valid_o <= slot_mask;
            out_taken_o      <= pred_taken_o;
        end
    end

    // payload follows the block
    always_ff @(posedge clk_i) begin
        if (blk_valid_i) begin
            out_addr_o   <= blk_addr_i;
            out_instr_o  <= slot_instr_i;
            out_cf_o     <= slot_cf_i;
            out_target_o <= pred_target_o;
        end
    end

endmodule

// ==== rtl/fe_params.svh ====
// Front-end width parameters

`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// ------------------------------------------------------------
// address and instruction widths
// ------------------------------------------------------------
// virtual address width of the core
`define FE_VLEN 32
// one uncompressed instruction word
`define FE_ILEN 32

// ------------------------------------------------------------
// fetch block geometry
// ------------------------------------------------------------
// instruction slots delivered per fetch response
`define FE_INSTR_PER_FETCH 2
// fetch block width, slots times instruction width
`define FE_FETCH_WIDTH 64
// low address bits that select a byte inside one block
`define FE_SLOT_SHIFT 3

`endif

// ==== rtl/fe_pkg.sv ====
// Front-end shared types

`include "fe_params.svh"

package fe_pkg;

    // ------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------
    // fetch or instruction address
    typedef logic [`FE_VLEN-1:0] vaddr_t;

    // single instruction word
    typedef logic [`FE_ILEN-1:0] instr_t;

    // whole fetch block as returned by the memory
    typedef logic [`FE_FETCH_WIDTH-1:0] fetch_data_t;

    // one bit per slot of a block
    typedef logic [`FE_INSTR_PER_FETCH-1:0] slot_mask_t;

    // ------------------------------------------------------------
    // control-flow class
    // ------------------------------------------------------------
    // jalr is only reported, the static predictor never takes it
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_JALR
    } cf_e;

endpackage

// ==== rtl/fetch_reg.sv ====
// Fetch response register

`timescale 1ns/100ps

`include "fe_params.svh"

module fetch_reg import fe_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   flush_i,
    // response strobe from the fetch memory
    input  logic                                   rsp_valid_i,
    input  vaddr_t                                 rsp_addr_i,
    input  fetch_data_t                            rsp_data_i,
    // registered block, split into slots
    output logic                                   blk_valid_o,
    output vaddr_t                                 blk_addr_o,
    output instr_t [`FE_INSTR_PER_FETCH-1:0]       slot_instr_o,
    output vaddr_t [`FE_INSTR_PER_FETCH-1:0]       slot_addr_o
);

    logic        valid_q;
    vaddr_t      addr_q;
    fetch_data_t data_q;

    // ------------------------------------------------------------
    // response capture
    // ------------------------------------------------------------
    // a response that meets a flush is thrown away
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rsp_valid_i & ~flush_i;
        end
    end

    // block payload, only loaded with a response
    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            addr_q <= rsp_addr_i;
            data_q <= rsp_data_i;
        end
    end

    // ------------------------------------------------------------
    // slot split
    // ------------------------------------------------------------
    assign blk_valid_o = valid_q;
    // block base, byte offset inside the block dropped
    assign blk_addr_o  = {addr_q[`FE_VLEN-1:`FE_SLOT_SHIFT], {`FE_SLOT_SHIFT{1'b0}}};

    // slot 0 is the low word, each higher slot one word further up
    for (genvar i = 0; i < `FE_INSTR_PER_FETCH; i++) begin : gen_slot
        assign slot_instr_o[i] = data_q[i*`FE_ILEN +: `FE_ILEN];
        assign slot_addr_o[i]  = blk_addr_o + vaddr_t'(i * (`FE_ILEN / 8));
    end

endmodule

// ==== rtl/frontend_top.sv ====
// Instruction fetch front end

`timescale 1ns/100ps

`include "fe_params.svh"

module frontend_top import fe_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  vaddr_t                                 boot_addr_i,
    // redirect from the back end
    input  logic                                   redirect_i,
    input  vaddr_t                                 redirect_addr_i,
    // fetch memory response
    input  logic                                   rsp_valid_i,
    input  vaddr_t                                 rsp_addr_i,
    input  fetch_data_t                            rsp_data_i,
    // fetch request
    output logic                                   fetch_req_o,
    output vaddr_t                                 fetch_addr_o,
    // decoded block towards the back end
    output logic                                   out_valid_o,
    output vaddr_t                                 out_addr_o,
    output instr_t [`FE_INSTR_PER_FETCH-1:0]       out_instr_o,
    output slot_mask_t                             out_slot_valid_o,
    output cf_e    [`FE_INSTR_PER_FETCH-1:0]       out_cf_o,
    output logic                                   out_taken_o,
    output vaddr_t                                 out_target_o
);

    logic                             blk_valid;
    vaddr_t                           blk_addr;
    instr_t [`FE_INSTR_PER_FETCH-1:0] slot_instr;
    vaddr_t [`FE_INSTR_PER_FETCH-1:0] slot_addr;
    cf_e    [`FE_INSTR_PER_FETCH-1:0] slot_cf;
    vaddr_t [`FE_INSTR_PER_FETCH-1:0] slot_imm;
    logic                             pred_taken;
    vaddr_t                           pred_target;

    // ------------------------------------------------------------
    // fetch register, redirect doubles as flush
    // ------------------------------------------------------------
    fetch_reg i_fetch_reg (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (redirect_i),
        .rsp_valid_i  (rsp_valid_i),
        .rsp_addr_i   (rsp_addr_i),
        .rsp_data_i   (rsp_data_i),
        .blk_valid_o  (blk_valid),
        .blk_addr_o   (blk_addr),
        .slot_instr_o (slot_instr),
        .slot_addr_o  (slot_addr)
    );

    // one scanner per slot
    for (genvar i = 0; i < `FE_INSTR_PER_FETCH; i++) begin : gen_instr_scan
        instr_scan i_instr_scan (
            .instr_i (slot_instr[i]),
            .cf_o    (slot_cf[i]),
            .imm_o   (slot_imm[i])
        );
    end

    // ------------------------------------------------------------
    // prediction and output stage
    // ------------------------------------------------------------
    branch_select i_branch_select (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (redirect_i),
        .blk_valid_i      (blk_valid),
        .blk_addr_i       (blk_addr),
        .slot_instr_i     (slot_instr),
        .slot_addr_i      (slot_addr),
        .slot_cf_i        (slot_cf),
        .slot_imm_i       (slot_imm),
        .pred_taken_o     (pred_taken),
        .pred_target_o    (pred_target),
        .out_valid_o      (out_valid_o),
        .out_addr_o       (out_addr_o),
        .out_instr_o      (out_instr_o),
        .out_slot_valid_o (out_slot_valid_o),
        .out_cf_o         (out_cf_o),
        .out_taken_o      (out_taken_o),
        .out_target_o     (out_target_o)
    );

    // next fetch address
    pc_gen i_pc_gen (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .boot_addr_i     (boot_addr_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .pred_taken_i    (pred_taken),
        .pred_target_i   (pred_target),
        .fetch_req_o     (fetch_req_o),
        .fetch_addr_o    (fetch_addr_o)
    );

endmodule

// ==== rtl/instr_scan.sv ====
// Control-flow instruction scanner

`timescale 1ns/100ps

`include "fe_params.svh"

module instr_scan import fe_pkg::*; (
    input  instr_t instr_i,
    output cf_e    cf_o,
    output vaddr_t imm_o
);

    // ------------------------------------------------------------
    // opcodes of interest
    // ------------------------------------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic   [6:0] opcode;
    vaddr_t       imm_b;
    vaddr_t       imm_j;
    vaddr_t       imm_i;

    assign opcode = instr_i[6:0];

    // ------------------------------------------------------------
    // immediate formats, all sign-extended to the address width
    // ------------------------------------------------------------
    // B-type, 13 bit offset with implicit zero lsb
    assign imm_b = {{(`FE_VLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    // J-type, 21 bit offset with implicit zero lsb
    assign imm_j = {{(`FE_VLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};
    // I-type, plain 12 bit
    assign imm_i = {{(`FE_VLEN-12){instr_i[31]}}, instr_i[31:20]};

    // ------------------------------------------------------------
    // classification
    // ------------------------------------------------------------
    always_comb begin
        cf_o  = CF_NONE;
        imm_o = '0;
        unique case (opcode)
            OPC_BRANCH: begin
                cf_o  = CF_BRANCH;
                imm_o = imm_b;
            end
            OPC_JAL: begin
                cf_o  = CF_JUMP;
                imm_o = imm_j;
            end
            // register target, offset still handed on for reporting
            OPC_JALR: begin
                cf_o  = CF_JALR;
                imm_o = imm_i;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/pc_gen.sv ====
// Next fetch address generator

`timescale 1ns/100ps

`include "fe_params.svh"

module pc_gen import fe_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  vaddr_t boot_addr_i,
    // mispredict or flush from the back end
    input  logic   redirect_i,
    input  vaddr_t redirect_addr_i,
    // static prediction of the block in the fetch register
    input  logic   pred_taken_i,
    input  vaddr_t pred_target_i,
    output logic   fetch_req_o,
    output vaddr_t fetch_addr_o
);

    logic   first_q;
    vaddr_t npc_d;
    vaddr_t npc_q;
    vaddr_t seq_addr;

    // ------------------------------------------------------------
    // next pc selection
    // ------------------------------------------------------------
    // sequential fetch steps one full block from the aligned base
    assign seq_addr = {npc_q[`FE_VLEN-1:`FE_SLOT_SHIFT], {`FE_SLOT_SHIFT{1'b0}}}
                      + vaddr_t'(`FE_FETCH_WIDTH / 8);

    // redirect beats boot load, prediction and sequential
    always_comb begin
        if (redirect_i) begin
            npc_d = redirect_addr_i;
        end else if (first_q) begin
            npc_d = boot_addr_i;
        end else if (pred_taken_i) begin
            npc_d = pred_target_i;
        end else begin
            npc_d = seq_addr;
        end
    end

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------
    // first_q marks the cycle right out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            first_q <= 1'b1;
            npc_q   <= '0;
        end else begin
            first_q <= 1'b0;
            npc_q   <= npc_d;
        end
    end

    // requests start once the boot address is loaded
    assign fetch_req_o  = ~first_q;
    assign fetch_addr_o = npc_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=frontend_tb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module "$TOP" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
exit 1

// ==== vlog.f ====
+incdir+rtl
rtl/fe_pkg.sv
rtl/fetch_reg.sv
rtl/instr_scan.sv
rtl/branch_select.sv
rtl/pc_gen.sv
rtl/frontend_top.sv
dv/frontend_assertions.sv
dv/frontend_tb.sv
